/* src.f */
+incdir+.
lsu_mem_pkg.sv
lsu_wb_pkg.sv
lsu_ifaces.sv
dmem_array.sv
mem_lane_align.sv
wb_select.sv
fwd_unit.sv
mem_wb_top.sv
tb_clkgen.sv
mem_wb_sva.sv
tb_mem_wb.sv

/* tb_mem_wb.sv */
`include "lsu_settings.svh"

module tb_mem_wb;
  import lsu_mem_pkg::*;
  import lsu_wb_pkg::*;

  localparam int period  = 100;
  // command cycles per test, summed for the watchdog
  localparam int lat_n   = 60;
  localparam int ext_n   = 24;
  localparam int mem_n   = 61;
  localparam int fwd_n   = 80;
  localparam int drain_n = 3;
  localparam int budget  = 17 + lat_n + ext_n + mem_n + fwd_n + 5 * drain_n + 50;

  logic                  clk;
  logic                  rst;
  logic                  mem_valid_i;
  logic                  mem_read_i;
  logic                  mem_write_i;
  logic                  mem_rd_wen_i;
  logic [`LSU_XLEN-1:0]  mem_addr_i;
  logic [`LSU_XLEN-1:0]  mem_wdata_i;
  logic [`LSU_XLEN-1:0]  mem_imm_i;
  logic [`LSU_XLEN-1:0]  mem_csr_i;
  byte_mask_t            mem_wmask_i;
  logic [`LSU_REG_W-1:0] mem_rd_i;
  rd_src_e               mem_rd_src_i;
  rd_ext_e               mem_rd_ext_i;
  logic [`LSU_REG_W-1:0] ex_rs1_i;
  logic [`LSU_REG_W-1:0] ex_rs2_i;
  logic                  ex_store_i;
  logic                  wb_valid_o;
  logic [`LSU_REG_W-1:0] wb_rd_o;
  logic                  wb_wen_o;
  logic [`LSU_XLEN-1:0]  wb_data_o;
  logic [`LSU_XLEN-1:0]  mem_fwd_data_o;
  logic [1:0]            fwd_a_sel_o;
  logic [1:0]            fwd_b_sel_o;
  logic [1:0]            fwd_wdata_sel_o;

  int seed = 77;
  int mark = 0;
  int tests_run = 0;

  tb_clkgen #(.period(period), .reset_cycles(16)) clkgen0 (.clk(clk), .rst(rst));

  mem_wb_top dut0 (.*);

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // one command in the memory stage for the next cycle
  task automatic issue(input logic [63:0] addr, input logic [63:0] wdata, input logic rd_en,
                       input logic wr_en, input byte_mask_t mask, input rd_src_e src,
                       input rd_ext_e ext, input logic [63:0] value);
    @(posedge clk);
    mem_valid_i  <= 1'b1;
    mem_addr_i   <= addr;
    mem_wdata_i  <= wdata;
    mem_read_i   <= rd_en;
    mem_write_i  <= wr_en;
    mem_wmask_i  <= mask;
    mem_rd_i     <= 5'($random(seed));
    mem_rd_wen_i <= !wr_en;
    mem_rd_src_i <= src;
    mem_rd_ext_i <= ext;
    mem_imm_i    <= value;
    mem_csr_i    <= value ^ 64'haaaa_5555_0000_0000;
  endtask

  task automatic idle();
    @(posedge clk);
    mem_valid_i <= 1'b0;
    mem_read_i  <= 1'b0;
    mem_write_i <= 1'b0;
    ex_store_i  <= 1'b0;
  endtask

  task automatic end_test(input string name);
    repeat (drain_n) idle();
    tests_run++;
    $display("test %s done, %0d assertion failures", name, dut0.sva0.fails - mark);
    mark = dut0.sva0.fails;
  endtask

  task automatic test_latency();
    int r;
    for (int i = 0; i < lat_n; i++) begin
      r = $random(seed);
      @(posedge clk);
      mem_valid_i  <= r[0];
      mem_read_i   <= r[1];
      mem_write_i  <= 1'b0;
      mem_rd_wen_i <= r[2];
      mem_rd_i     <= r[8:4];
      mem_rd_src_i <= rd_src_e'(r[10:9]);
      mem_rd_ext_i <= rd_ext_e'(r[13:11]);
      mem_addr_i   <= rand64();
      mem_imm_i    <= rand64();
      mem_csr_i    <= rand64();
    end
    end_test("latency");
  endtask

  task automatic test_ext();
    rd_src_e     srcs [3];
    logic [63:0] v;
    srcs = '{src_alu, src_imm, src_csr};
    for (int s = 0; s < 3; s++) begin
      for (int e = 0; e < 8; e++) begin
        v = rand64();
        // sign bits 7, 15 and 31 set for some codes and clear for others
        v = (e[1] ^ s[0]) ? (v & ~64'h8000_8080) : (v | 64'h8000_8080);
        issue(v, 64'd0, 1'b0, 1'b0, 8'h00, srcs[s], rd_ext_e'(e[2:0]), v);
      end
    end
    end_test("ext");
  endtask

  task automatic test_mem();
    logic [63:0] base;
    base = 64'h0000_0000_0000_1a40;
    // whole double first, then byte and half stores on top
    issue(base, rand64(), 1'b0, 1'b1, 8'hff, src_alu, ext_d, 64'd0);
    issue(base + 1, rand64(), 1'b0, 1'b1, 8'h01, src_alu, ext_d, 64'd0);
    issue(base + 6, rand64(), 1'b0, 1'b1, 8'h01, src_alu, ext_d, 64'd0);
    issue(base + 2, rand64(), 1'b0, 1'b1, 8'h03, src_alu, ext_d, 64'd0);
    // upper byte of this half falls past lane 7
    issue(base + 7, rand64(), 1'b0, 1'b1, 8'h03, src_alu, ext_d, 64'd0);
    for (int off = 0; off < 8; off++) begin
      for (int e = 0; e < 7; e++) begin
        issue(base + off, 64'd0, 1'b1, 1'b0, 8'h00, src_mem, rd_ext_e'(e[2:0]), 64'd0);
      end
    end
    end_test("mem");
  endtask

  task automatic test_fwd();
    int r;
    for (int i = 0; i < fwd_n; i++) begin
      r = $random(seed);
      @(posedge clk);
      // small register range so both stages hit often
      mem_valid_i  <= r[0];
      mem_rd_wen_i <= r[1];
      mem_rd_i     <= 5'(r[3:2]);
      ex_rs1_i     <= 5'(r[5:4]);
      ex_rs2_i     <= 5'(r[7:6]);
      ex_store_i   <= r[8];
      mem_read_i   <= 1'b0;
      mem_write_i  <= 1'b0;
      mem_rd_src_i <= src_alu;
      mem_rd_ext_i <= ext_d;
      mem_addr_i   <= rand64();
    end
    end_test("fwd");
  endtask

  initial begin
    mem_valid_i  = 1'b0;
    mem_read_i   = 1'b0;
    mem_write_i  = 1'b0;
    mem_rd_wen_i = 1'b0;
    mem_addr_i   = '0;
    mem_wdata_i  = '0;
    mem_imm_i    = '0;
    mem_csr_i    = '0;
    mem_wmask_i  = '0;
    mem_rd_i     = '0;
    mem_rd_src_i = src_alu;
    mem_rd_ext_i = ext_d;
    ex_rs1_i     = '0;
    ex_rs2_i     = '0;
    ex_store_i   = 1'b0;
    // reset checks run on their own while rst is high
    while (rst !== 1'b0) begin
      @(posedge clk);
    end
    end_test("reset");
    test_latency();
    test_ext();
    test_mem();
    test_fwd();
    $display("tests run %0d, assertion failures %0d", tests_run, dut0.sva0.fails);
    if (dut0.sva0.fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #(budget * period);
    $display("watchdog: run did not finish within %0d cycles", budget);
    $display("Regression failed");
    $finish;
  end

endmodule

/* mem_wb_sva.sv */
`include "lsu_settings.svh"

module mem_wb_sva (
  input logic                      clk,
  input logic                      rst,
  input logic                      mem_valid_i,
  input logic [`LSU_XLEN-1:0]      mem_addr_i,
  input logic [`LSU_XLEN-1:0]      mem_wdata_i,
  input logic                      mem_read_i,
  input logic                      mem_write_i,
  input lsu_mem_pkg::byte_mask_t   mem_wmask_i,
  input logic [`LSU_REG_W-1:0]     mem_rd_i,
  input logic                      mem_rd_wen_i,
  input lsu_wb_pkg::rd_src_e       mem_rd_src_i,
  input lsu_wb_pkg::rd_ext_e       mem_rd_ext_i,
  input logic [`LSU_XLEN-1:0]      mem_imm_i,
  input logic [`LSU_XLEN-1:0]      mem_csr_i,
  input logic [`LSU_REG_W-1:0]     ex_rs1_i,
  input logic [`LSU_REG_W-1:0]     ex_rs2_i,
  input logic                      ex_store_i,
  input logic                      wb_valid_o,
  input logic [`LSU_REG_W-1:0]     wb_rd_o,
  input logic                      wb_wen_o,
  input logic [`LSU_XLEN-1:0]      wb_data_o,
  input logic [`LSU_XLEN-1:0]      mem_fwd_data_o,
  input logic [1:0]                fwd_a_sel_o,
  input logic [1:0]                fwd_b_sel_o,
  input logic [1:0]                fwd_wdata_sel_o
);
  import lsu_mem_pkg::*;
  import lsu_wb_pkg::*;

  localparam int idx_w = `LSU_DMEM_IDX_W;

  int fails = 0;

  logic                  rst_q;
  logic                  exp_valid;
  logic                  exp_wen;
  logic                  exp_data_chk;
  logic [`LSU_REG_W-1:0] exp_rd;
  logic [`LSU_XLEN-1:0]  exp_data;
  logic [`LSU_XLEN-1:0]  raw;
  logic [idx_w-1:0]      cmd_idx;
  logic [idx_w-1:0]      shadow_idx;
  logic [`LSU_XLEN-1:0]  shadow_word;
  logic                  shadow_ok;
  logic                  load_chk;
  logic [`LSU_XLEN-1:0]  load_exp;
  logic [1:0]            exp_a;
  logic [1:0]            exp_b;
  logic [1:0]            exp_w;

  function automatic logic [63:0] extend(input logic [63:0] v, input rd_ext_e code);
    case (code)
      ext_b:   return {{56{v[7]}}, v[7:0]};
      ext_bu:  return {56'd0, v[7:0]};
      ext_h:   return {{48{v[15]}}, v[15:0]};
      ext_hu:  return {48'd0, v[15:0]};
      ext_w:   return {{32{v[31]}}, v[31:0]};
      ext_wu:  return {32'd0, v[31:0]};
      ext_d:   return v;
      default: return '0;
    endcase
  endfunction

  // byte merge of a store into an older word
  function automatic logic [63:0] merge(input logic [63:0] old, input logic [63:0] wdata,
                                        input byte_mask_t mask, input logic [2:0] off);
    byte_mask_t  m;
    logic [63:0] d;
    logic [63:0] r;
    m = mask << off;
    d = wdata << (8 * off);
    r = old;
    for (int i = 0; i < 8; i++) begin
      if (m[i]) begin
        r[8*i +: 8] = d[8*i +: 8];
      end
    end
    return r;
  endfunction

  function automatic logic [1:0] pick(input logic [`LSU_REG_W-1:0] rs, input logic mem_hit,
                                      input logic wb_hit);
    if (rs == '0) begin
      return 2'd0;
    end else if (mem_hit) begin
      return 2'd2;
    end else if (wb_hit) begin
      return 2'd1;
    end
    return 2'd0;
  endfunction

  // raw write-back value, memory source is covered by the load check
  always_comb begin
    case (mem_rd_src_i)
      src_alu: raw = mem_addr_i;
      src_imm: raw = mem_imm_i;
      src_csr: raw = mem_csr_i;
      default: raw = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    rst_q <= rst;
    if (rst) begin
      exp_valid    <= 1'b0;
      exp_wen      <= 1'b0;
      exp_data_chk <= 1'b0;
      exp_rd       <= '0;
      exp_data     <= '0;
    end else begin
      exp_valid    <= mem_valid_i;
      exp_wen      <= mem_valid_i & mem_rd_wen_i;
      exp_data_chk <= mem_valid_i && (mem_rd_src_i != src_mem);
      exp_rd       <= mem_rd_i;
      exp_data     <= extend(raw, mem_rd_ext_i);
    end
  end

  assign cmd_idx = mem_addr_i[3 +: idx_w];

  // shadow of one memory word, known only once every byte was written
  always_ff @(posedge clk) begin
    if (rst) begin
      shadow_ok   <= 1'b0;
      shadow_idx  <= '0;
      shadow_word <= '0;
    end else if (mem_valid_i && mem_write_i) begin
      shadow_idx <= cmd_idx;
      if (shadow_ok && (cmd_idx == shadow_idx)) begin
        shadow_word <= merge(shadow_word, mem_wdata_i, mem_wmask_i, mem_addr_i[2:0]);
      end else begin
        shadow_word <= merge('0, mem_wdata_i, mem_wmask_i, mem_addr_i[2:0]);
        shadow_ok   <= (byte_mask_t'(mem_wmask_i << mem_addr_i[2:0]) == 8'hff);
      end
    end
  end

  assign load_chk = mem_valid_i && mem_read_i && (mem_rd_src_i == src_mem) &&
                    shadow_ok && (cmd_idx == shadow_idx);
  assign load_exp = extend(shadow_word >> (8 * mem_addr_i[2:0]), mem_rd_ext_i);

  assign exp_a = pick(ex_rs1_i, mem_valid_i && mem_rd_wen_i && (mem_rd_i == ex_rs1_i),
                      wb_wen_o && (wb_rd_o == ex_rs1_i));
  assign exp_b = pick(ex_rs2_i, mem_valid_i && mem_rd_wen_i && (mem_rd_i == ex_rs2_i),
                      wb_wen_o && (wb_rd_o == ex_rs2_i));
  // store data ignores both write enables
  assign exp_w = ex_store_i ? pick(ex_rs2_i, mem_valid_i && (mem_rd_i == ex_rs2_i),
                                   wb_rd_o == ex_rs2_i) : 2'd0;

  a_reset: assert property (@(posedge clk)
    rst_q |-> !wb_valid_o && !wb_wen_o && wb_data_o == '0)
    else begin
      fails++;
      $error("** Error t=%0t wb_valid_o/wb_wen_o/wb_data_o got %b/%b/%h expected 0/0/0",
             $time, $sampled(wb_valid_o), $sampled(wb_wen_o), $sampled(wb_data_o));
    end
  a_wb_valid: assert property (@(posedge clk) disable iff (rst) wb_valid_o == exp_valid)
    else begin
      fails++;
      $error("** Error t=%0t wb_valid_o got %b expected %b",
             $time, $sampled(wb_valid_o), $sampled(exp_valid));
    end
  a_wb_rd: assert property (@(posedge clk) disable iff (rst) exp_valid |-> wb_rd_o == exp_rd)
    else begin
      fails++;
      $error("** Error t=%0t wb_rd_o got %0d expected %0d",
             $time, $sampled(wb_rd_o), $sampled(exp_rd));
    end
  a_wb_wen: assert property (@(posedge clk) disable iff (rst) wb_wen_o == exp_wen)
    else begin
      fails++;
      $error("** Error t=%0t wb_wen_o got %b expected %b",
             $time, $sampled(wb_wen_o), $sampled(exp_wen));
    end
  a_wb_data: assert property (@(posedge clk) disable iff (rst)
    exp_data_chk |-> wb_data_o == exp_data)
    else begin
      fails++;
      $error("** Error t=%0t wb_data_o got %h expected %h",
             $time, $sampled(wb_data_o), $sampled(exp_data));
    end
  a_load: assert property (@(posedge clk) disable iff (rst)
    load_chk |-> mem_fwd_data_o == load_exp)
    else begin
      fails++;
      $error("** Error t=%0t mem_fwd_data_o got %h expected %h",
             $time, $sampled(mem_fwd_data_o), $sampled(load_exp));
    end
  a_fwd_a: assert property (@(posedge clk) disable iff (rst) fwd_a_sel_o == exp_a)
    else begin
      fails++;
      $error("** Error t=%0t fwd_a_sel_o got %0d expected %0d",
             $time, $sampled(fwd_a_sel_o), $sampled(exp_a));
    end
  a_fwd_b: assert property (@(posedge clk) disable iff (rst) fwd_b_sel_o == exp_b)
    else begin
      fails++;
      $error("** Error t=%0t fwd_b_sel_o got %0d expected %0d",
             $time, $sampled(fwd_b_sel_o), $sampled(exp_b));
    end
  a_fwd_w: assert property (@(posedge clk) disable iff (rst) fwd_wdata_sel_o == exp_w)
    else begin
      fails++;
      $error("** Error t=%0t fwd_wdata_sel_o got %0d expected %0d",
             $time, $sampled(fwd_wdata_sel_o), $sampled(exp_w));
    end

endmodule

bind mem_wb_top mem_wb_sva sva0 (.*);

/* tb_clkgen.sv */
module tb_clkgen #(
  parameter int period       = 100,
  parameter int reset_cycles = 16
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // reset held for a fixed count of rising edges
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* mem_wb_top.sv */
`include "lsu_settings.svh"

module mem_wb_top (
  input  logic                      clk,
  input  logic                      rst,

  // memory-stage command
  input  logic                      mem_valid_i,
  input  logic [`LSU_XLEN-1:0]      mem_addr_i,
  input  logic [`LSU_XLEN-1:0]      mem_wdata_i,
  input  logic                      mem_read_i,
  input  logic                      mem_write_i,
  input  lsu_mem_pkg::byte_mask_t   mem_wmask_i,
  input  logic [`LSU_REG_W-1:0]     mem_rd_i,
  input  logic                      mem_rd_wen_i,
  input  lsu_wb_pkg::rd_src_e       mem_rd_src_i,
  input  lsu_wb_pkg::rd_ext_e       mem_rd_ext_i,
  input  logic [`LSU_XLEN-1:0]      mem_imm_i,
  input  logic [`LSU_XLEN-1:0]      mem_csr_i,

  // execute-stage operands
  input  logic [`LSU_REG_W-1:0]     ex_rs1_i,
  input  logic [`LSU_REG_W-1:0]     ex_rs2_i,
  input  logic                      ex_store_i,

  // write-back stage
  output logic                      wb_valid_o,
  output logic [`LSU_REG_W-1:0]     wb_rd_o,
  output logic                      wb_wen_o,
  output logic [`LSU_XLEN-1:0]      wb_data_o,

  // forwarding
  output logic [`LSU_XLEN-1:0]      mem_fwd_data_o,
  output logic [1:0]                fwd_a_sel_o,
  output logic [1:0]                fwd_b_sel_o,
  output logic [1:0]                fwd_wdata_sel_o
);
  import lsu_mem_pkg::*;

  lane_word_u load_data;

  mem_cmd_if  cmd_if ();
  dmem_bus_if dmem_if ();
  wb_bus_if   wb_if ();

  // command bundle from the plain ports
  assign cmd_if.valid  = mem_valid_i;
  assign cmd_if.addr   = mem_addr_i;
  assign cmd_if.wdata  = mem_wdata_i;
  assign cmd_if.read   = mem_read_i;
  assign cmd_if.write  = mem_write_i;
  assign cmd_if.wmask  = mem_wmask_i;
  assign cmd_if.rd     = mem_rd_i;
  assign cmd_if.rd_wen = mem_rd_wen_i;
  assign cmd_if.rd_src = mem_rd_src_i;
  assign cmd_if.rd_ext = mem_rd_ext_i;
  assign cmd_if.imm    = mem_imm_i;
  assign cmd_if.csr    = mem_csr_i;

  dmem_array u_dmem (
    .clk  (clk),
    .dmem (dmem_if.memory)
  );

  mem_lane_align u_align (
    .cmd         (cmd_if.consumer),
    .dmem        (dmem_if.requester),
    .load_data_o (load_data)
  );

  wb_select u_wb (
    .clk         (clk),
    .rst         (rst),
    .cmd         (cmd_if.consumer),
    .load_data_i (load_data),
    .fwd_data_o  (mem_fwd_data_o),
    .wb          (wb_if.producer)
  );

  fwd_unit u_fwd (
    .cmd             (cmd_if.consumer),
    .wb              (wb_if.observer),
    .ex_rs1_i        (ex_rs1_i),
    .ex_rs2_i        (ex_rs2_i),
    .ex_store_i      (ex_store_i),
    .fwd_a_sel_o     (fwd_a_sel_o),
    .fwd_b_sel_o     (fwd_b_sel_o),
    .fwd_wdata_sel_o (fwd_wdata_sel_o)
  );

  // write-back register to the plain ports
  assign wb_valid_o = wb_if.valid;
  assign wb_rd_o    = wb_if.rd;
  assign wb_wen_o   = wb_if.wen;
  assign wb_data_o  = wb_if.data;

endmodule

/* fwd_unit.sv */
`include "lsu_settings.svh"

module fwd_unit (
  mem_cmd_if.consumer            cmd,
  wb_bus_if.observer             wb,
  input  logic [`LSU_REG_W-1:0]  ex_rs1_i,
  input  logic [`LSU_REG_W-1:0]  ex_rs2_i,
  input  logic                   ex_store_i,
  output logic [1:0]             fwd_a_sel_o,
  output logic [1:0]             fwd_b_sel_o,
  output logic [1:0]             fwd_wdata_sel_o
);

  // 2 takes the memory stage, 1 takes write-back, 0 the register file
  // memory stage first so the youngest producer wins
  function automatic logic [1:0] operand_sel(input logic [`LSU_REG_W-1:0] rs);
    if (rs == '0) begin
      return 2'd0;
    end else if (cmd.valid && cmd.rd_wen && (cmd.rd == rs)) begin
      return 2'd2;
    end else if (wb.wen && (wb.rd == rs)) begin
      return 2'd1;
    end
    return 2'd0;
  endfunction

  always_comb begin
    fwd_a_sel_o = operand_sel(ex_rs1_i);
    fwd_b_sel_o = operand_sel(ex_rs2_i);
  end

  // store data select, rd_wen is not looked at here
  always_comb begin
    if (!ex_store_i || (ex_rs2_i == '0)) begin
      fwd_wdata_sel_o = 2'd0;
    end else if (cmd.valid && (cmd.rd == ex_rs2_i)) begin
      fwd_wdata_sel_o = 2'd2;
    end else if (wb.rd == ex_rs2_i) begin
      fwd_wdata_sel_o = 2'd1;
    end else begin
      fwd_wdata_sel_o = 2'd0;
    end
  end

endmodule

/* wb_select.sv */
`include "lsu_settings.svh"

module wb_select (
  input  logic                      clk,
  input  logic                      rst,
  mem_cmd_if.consumer               cmd,
  input  lsu_mem_pkg::lane_word_u   load_data_i,
  output logic [`LSU_XLEN-1:0]      fwd_data_o,
  wb_bus_if.producer                wb
);
  import lsu_mem_pkg::*;
  import lsu_wb_pkg::*;

  lane_word_u raw;

  // raw result by source
  // the alu result arrives on the address lines
  always_comb begin
    case (cmd.rd_src)
      src_alu: raw = cmd.addr;
      src_mem: raw = load_data_i;
      src_imm: raw = cmd.imm;
      src_csr: raw = cmd.csr;
      default: raw = '0;
    endcase
  end

  // extension to full width
  // byte from the lane view, half, word and double from the field view
  always_comb begin
    case (cmd.rd_ext)
      ext_b:   fwd_data_o = {{56{raw.lane[0][7]}}, raw.lane[0]};
      ext_bu:  fwd_data_o = {56'd0, raw.lane[0]};
      ext_h:   fwd_data_o = {{48{raw.fld[0][0][15]}}, raw.fld[0][0]};
      ext_hu:  fwd_data_o = {48'd0, raw.fld[0][0]};
      ext_w:   fwd_data_o = {{32{raw.fld[0][1][15]}}, raw.fld[0]};
      ext_wu:  fwd_data_o = {32'd0, raw.fld[0]};
      ext_d:   fwd_data_o = raw.fld;
      default: fwd_data_o = '0;
    endcase
  end

  // write-back register
  // loaded every cycle, so an idle cycle leaves valid low
  always_ff @(posedge clk) begin
    if (rst) begin
      wb.valid <= 1'b0;
      wb.rd    <= '0;
      wb.wen   <= 1'b0;
      wb.data  <= '0;
    end else begin
      wb.valid <= cmd.valid;
      wb.rd    <= cmd.rd;
      wb.wen   <= cmd.valid & cmd.rd_wen;
      wb.data  <= fwd_data_o;
    end
  end

endmodule

/* mem_lane_align.sv */
`include "lsu_settings.svh"

module mem_lane_align (
  mem_cmd_if.consumer                cmd,
  dmem_bus_if.requester              dmem,
  output lsu_mem_pkg::lane_word_u    load_data_o
);
  import lsu_mem_pkg::*;

  logic [2:0]  byte_off;
  logic [5:0]  bit_off;
  byte_mask_t  lane_mask;
  lane_word_u  rd_word;
  lane_word_u  st_data;
  lane_word_u  merged;

  // byte offset inside the 64-bit word
  assign byte_off = cmd.addr[2:0];
  assign bit_off  = {byte_off, 3'b000};

  // word index, wraps at the memory depth
  assign dmem.index = cmd.addr[3 +: `LSU_DMEM_IDX_W];

  assign rd_word = dmem.rdata;

  // load path
  // shift the addressed byte down to lane 0, zero fill from the top
  // only a load enables the read data, as the old read strobe did
  always_comb begin
    if (cmd.read) begin
      load_data_o = mem_word_t'(rd_word >> bit_off);
    end else begin
      load_data_o = '0;
    end
  end

  // store path
  // mask bits pushed past lane 7 drop off
  assign lane_mask = cmd.wmask << byte_off;
  assign st_data   = mem_word_t'(cmd.wdata << bit_off);

  // read-modify-write
  // enabled lanes take store data, the rest keep the old byte
  always_comb begin
    merged = rd_word;
    for (int i = 0; i < 8; i++) begin
      if (lane_mask[i]) begin
        merged.lane[i] = st_data.lane[i];
      end
    end
  end

  assign dmem.wdata = merged;

  // write only for a valid store command
  assign dmem.we = cmd.valid & cmd.write;

endmodule

/* dmem_array.sv */
`include "lsu_settings.svh"

module dmem_array (
  input logic        clk,
  dmem_bus_if.memory dmem
);
  import lsu_mem_pkg::*;

  // word storage, contents undefined until written
  mem_word_t mem [`LSU_DMEM_WORDS];

  // combinational read of the addressed word
  assign dmem.rdata = mem[dmem.index];

  // the requester already merged the bytes, so a write
  // replaces the whole word
  always_ff @(posedge clk) begin
    if (dmem.we) begin
      mem[dmem.index] <= dmem.wdata;
    end
  end

endmodule

/* lsu_ifaces.sv */
`include "lsu_settings.svh"

// memory-stage command
interface mem_cmd_if;
  import lsu_mem_pkg::*;
  import lsu_wb_pkg::*;

  logic                   valid;
  logic [`LSU_XLEN-1:0]   addr;
  logic [`LSU_XLEN-1:0]   wdata;
  logic                   read;
  logic                   write;
  byte_mask_t             wmask;
  logic [`LSU_REG_W-1:0]  rd;
  logic                   rd_wen;
  rd_src_e                rd_src;
  rd_ext_e                rd_ext;
  logic [`LSU_XLEN-1:0]   imm;
  logic [`LSU_XLEN-1:0]   csr;

  modport consumer (
    input valid, addr, wdata, read, write, wmask,
    input rd, rd_wen, rd_src, rd_ext, imm, csr
  );
endinterface

// data memory port
interface dmem_bus_if;
  import lsu_mem_pkg::*;

  logic [`LSU_DMEM_IDX_W-1:0] index;
  mem_word_t                  rdata;
  mem_word_t                  wdata;
  logic                       we;

  modport requester (output index, wdata, we, input rdata);
  modport memory    (input index, wdata, we, output rdata);
endinterface

// write-back stage register contents
interface wb_bus_if;
  logic                   valid;
  logic [`LSU_REG_W-1:0]  rd;
  logic                   wen;
  logic [`LSU_XLEN-1:0]   data;

  modport producer (output valid, rd, wen, data);
  modport observer (input valid, rd, wen, data);
endinterface

/* lsu_wb_pkg.sv */
package lsu_wb_pkg;

  // write-back result source
  typedef enum logic [1:0] {
    src_alu = 2'd0,
    src_mem = 2'd1,
    src_imm = 2'd2,
    src_csr = 2'd3
  } rd_src_e;

  // write-back extension
  // the u variants zero extend, the others sign extend
  // code 7 is unused and gives zero
  typedef enum logic [2:0] {
    ext_b  = 3'd0,
    ext_bu = 3'd1,
    ext_h  = 3'd2,
    ext_hu = 3'd3,
    ext_w  = 3'd4,
    ext_wu = 3'd5,
    ext_d  = 3'd6
  } rd_ext_e;

endpackage

/* lsu_mem_pkg.sv */
`include "lsu_settings.svh"

package lsu_mem_pkg;

  // one stored memory word
  typedef logic [`LSU_XLEN-1:0] mem_word_t;

  // store byte mask, bit i enables byte lane i
  typedef logic [`LSU_XLEN/8-1:0] byte_mask_t;

  // memory word seen two ways
  //   lane    eight byte lanes, lane 0 is the lowest byte
  //   fld     fld is the double, fld[i] a word, fld[i][j] a half
  typedef union packed {
    logic [7:0][7:0]        lane;
    logic [1:0][1:0][15:0]  fld;
  } lane_word_u;

endpackage

/* lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data and address width
`define LSU_XLEN 64

// register index width
`define LSU_REG_W 5

// data memory depth in 64-bit words
`define LSU_DMEM_WORDS 256

// word index width, address bits above bit 2
`define LSU_DMEM_IDX_W $clog2(`LSU_DMEM_WORDS)

`endif
